/* Makefile */
# Verilator build and run of the execute stage testbench
TOP = ex_stage_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

/* common/ex_pkg.sv */
/*
  Shared widths, operator encodings and port structs of the execute stage.
  Only the integer subset is kept: no FPU, no divider, no DSP modes.
  MULH_STEPS must divide XLEN; each step consumes one slice of operand b.
*/

package ex_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  // Data word width
  localparam int XLEN = 32;

  // Register address, 6 bits as on the ID side
  localparam int REG_ADDR_W = 6;

  // Upper-word multiply iterations and the slice of b handled per step
  localparam int MULH_STEPS   = 4;
  localparam int MULH_SLICE_W = XLEN / MULH_STEPS;
  localparam int MULH_CNT_W   = $clog2(MULH_STEPS);

  ////////////////////////////////////////////////////////////////////////////
  // Operator encodings
  ////////////////////////////////////////////////////////////////////////////

  // SLT/SLTU write 0 or 1, EQ..GEU are branch compares
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  // MUL/MAC single cycle, MULH* iterative
  typedef enum logic [2:0] {
    MULT_MUL,
    MULT_MAC,
    MULT_MULH,
    MULT_MULHSU,
    MULT_MULHU
  } mult_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // Port structs
  ////////////////////////////////////////////////////////////////////////////

  // ALU request from ID
  typedef struct packed {
    alu_op_e         op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
  } alu_req_t;

  // Multiplier request from ID, c is the accumulator for MAC
  typedef struct packed {
    mult_op_e        op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] c;
  } mult_req_t;

  // Register file write port, used for forwarding and for load/store
  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] addr;
    logic [XLEN-1:0]       data;
  } wb_port_t;

endpackage

/* rtl/alu/ex_alu.sv */
/*
  Single-cycle integer ALU, purely combinational.
  One subtractor serves SUB, SLT/SLTU and all branch compares.
  Compare operators return the compare bit zero-extended on result_o.
*/

`timescale 1ns/1ns

module ex_alu
  import ex_pkg::*;
(
  input  alu_req_t        alu_req_i,
  output logic [XLEN-1:0] result_o,
  output logic            cmp_result_o
);

  // Operand aliases
  logic [XLEN-1:0]         op_a;
  logic [XLEN-1:0]         op_b;
  logic [$clog2(XLEN)-1:0] shamt;

  // Adder and shared subtractor
  logic [XLEN-1:0] add_res;
  logic [XLEN:0]   sub_full;

  // Compare flags
  logic is_eq;
  logic lt_signed;
  logic lt_unsigned;

  assign op_a  = alu_req_i.a;
  assign op_b  = alu_req_i.b;
  // Shift amount from the low bits of b
  assign shamt = op_b[$clog2(XLEN)-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // Arithmetic
  ////////////////////////////////////////////////////////////////////////////

  assign add_res = op_a + op_b;

  // a - b as a + ~b + 1, carry out kept in the top bit
  assign sub_full = {1'b0, op_a} + {1'b0, ~op_b} + (XLEN+1)'(1);

  // Zero difference means equal
  assign is_eq = (sub_full[XLEN-1:0] == '0);

  // No carry out means a < b unsigned
  assign lt_unsigned = ~sub_full[XLEN];

  // Signs differ: a is smaller when negative
  // Signs equal: the difference cannot overflow, its sign decides
  assign lt_signed = (op_a[XLEN-1] ^ op_b[XLEN-1]) ? op_a[XLEN-1] : sub_full[XLEN-1];

  ////////////////////////////////////////////////////////////////////////////
  // Compare output
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (alu_req_i.op)
      ALU_EQ:   cmp_result_o = is_eq;
      ALU_NE:   cmp_result_o = ~is_eq;
      ALU_LT:   cmp_result_o = lt_signed;
      ALU_GE:   cmp_result_o = ~lt_signed;
      ALU_LTU:  cmp_result_o = lt_unsigned;
      ALU_GEU:  cmp_result_o = ~lt_unsigned;
      // Set-less-than uses the same bit
      ALU_SLT:  cmp_result_o = lt_signed;
      ALU_SLTU: cmp_result_o = lt_unsigned;
      default:  cmp_result_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (alu_req_i.op)
      ALU_ADD: result_o = add_res;
      ALU_SUB: result_o = sub_full[XLEN-1:0];
      ALU_XOR: result_o = op_a ^ op_b;
      ALU_OR:  result_o = op_a | op_b;
      ALU_AND: result_o = op_a & op_b;
      ALU_SLL: result_o = op_a << shamt;
      ALU_SRL: result_o = op_a >> shamt;
      // Arithmetic shift keeps the sign of a
      ALU_SRA: result_o = $unsigned($signed(op_a) >>> shamt);
      // SLT/SLTU and branch compares write 0 or 1
      default: result_o = {{(XLEN-1){1'b0}}, cmp_result_o};
    endcase
  end

endmodule

/* rtl/ex_stage.sv */
/*
  Execute stage top: ALU and multiplier side by side, merged in writeback.
  ID must hold all inputs stable while ex_ready_o is low.
*/

`timescale 1ns/1ns

module ex_stage
  import ex_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  // ALU request
  input  logic                  alu_en_i,
  input  alu_req_t              alu_req_i,
  // Multiplier request
  input  logic                  mult_en_i,
  input  mult_req_t             mult_req_i,
  // Branch target, operand c of the branch
  input  logic [XLEN-1:0]       jump_target_src_i,
  // CSR read
  input  logic                  csr_access_i,
  input  logic [XLEN-1:0]       csr_rdata_i,
  // Load/store unit
  input  logic                  lsu_en_i,
  input  logic [XLEN-1:0]       lsu_rdata_i,
  input  logic                  lsu_ready_ex_i,
  input  logic                  lsu_err_i,
  input  logic                  branch_in_ex_i,
  // Forwarding port destination
  input  logic                  regfile_alu_we_i,
  input  logic [REG_ADDR_W-1:0] regfile_alu_waddr_i,
  // Load/store port destination
  input  logic                  regfile_we_i,
  input  logic [REG_ADDR_W-1:0] regfile_waddr_i,
  input  logic                  wb_ready_i,
  output wb_port_t              fw_port_o,
  output wb_port_t              wb_port_o,
  output logic                  branch_decision_o,
  output logic [XLEN-1:0]       jump_target_o,
  output logic                  mult_multicycle_o,
  output logic                  ex_ready_o,
  output logic                  ex_valid_o
);

  logic [XLEN-1:0] alu_result;
  logic            alu_cmp;
  logic [XLEN-1:0] mult_result;
  logic            mult_ready;

  // Branch outcome straight from the compare
  assign branch_decision_o = alu_cmp;
  assign jump_target_o     = jump_target_src_i;

  ////////////////////////////////////////////////////////////////////////////
  // Units
  ////////////////////////////////////////////////////////////////////////////

  ex_alu u_alu (
    .alu_req_i    (alu_req_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp)
  );

  // ex_ready_o releases a finished upper word
  ex_mult u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .mult_req_i   (mult_req_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .multicycle_o (mult_multicycle_o),
    .ready_o      (mult_ready)
  );

  ex_writeback u_writeback (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_en_i            (alu_en_i),
    .alu_result_i        (alu_result),
    .mult_en_i           (mult_en_i),
    .mult_result_i       (mult_result),
    .mult_ready_i        (mult_ready),
    .csr_access_i        (csr_access_i),
    .csr_rdata_i         (csr_rdata_i),
    .lsu_en_i            (lsu_en_i),
    .lsu_rdata_i         (lsu_rdata_i),
    .lsu_ready_ex_i      (lsu_ready_ex_i),
    .lsu_err_i           (lsu_err_i),
    .branch_in_ex_i      (branch_in_ex_i),
    .regfile_alu_we_i    (regfile_alu_we_i),
    .regfile_alu_waddr_i (regfile_alu_waddr_i),
    .regfile_we_i        (regfile_we_i),
    .regfile_waddr_i     (regfile_waddr_i),
    .wb_ready_i          (wb_ready_i),
    .fw_port_o           (fw_port_o),
    .wb_port_o           (wb_port_o),
    .ex_ready_o          (ex_ready_o),
    .ex_valid_o          (ex_valid_o)
  );

endmodule

/* rtl/ex_writeback.sv */
/*
  Write-port muxing and stall logic of the execute stage.
  The forwarding port is combinational, the load/store port is registered.
  ex_valid_o does not depend on ex_ready_o, so branches can retire in EX.
*/

`timescale 1ns/1ns

module ex_writeback
  import ex_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  alu_en_i,
  input  logic [XLEN-1:0]       alu_result_i,
  input  logic                  mult_en_i,
  input  logic [XLEN-1:0]       mult_result_i,
  input  logic                  mult_ready_i,
  input  logic                  csr_access_i,
  input  logic [XLEN-1:0]       csr_rdata_i,
  input  logic                  lsu_en_i,
  input  logic [XLEN-1:0]       lsu_rdata_i,
  input  logic                  lsu_ready_ex_i,
  input  logic                  lsu_err_i,
  input  logic                  branch_in_ex_i,
  input  logic                  regfile_alu_we_i,
  input  logic [REG_ADDR_W-1:0] regfile_alu_waddr_i,
  input  logic                  regfile_we_i,
  input  logic [REG_ADDR_W-1:0] regfile_waddr_i,
  input  logic                  wb_ready_i,
  output wb_port_t              fw_port_o,
  output wb_port_t              wb_port_o,
  output logic                  ex_ready_o,
  output logic                  ex_valid_o
);

  // EX/WB register of the load/store port
  logic                  lsu_we_q;
  logic [REG_ADDR_W-1:0] lsu_waddr_q;

  logic units_ready;
  logic lsu_we_masked;

  ////////////////////////////////////////////////////////////////////////////
  // Forwarding port
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    fw_port_o.we   = regfile_alu_we_i;
    fw_port_o.addr = regfile_alu_waddr_i;
    // CSR beats multiplier beats ALU
    if (csr_access_i) begin
      fw_port_o.data = csr_rdata_i;
    end else if (mult_en_i) begin
      fw_port_o.data = mult_result_i;
    end else if (alu_en_i) begin
      fw_port_o.data = alu_result_i;
    end else begin
      fw_port_o.data = '0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Ready and valid
  ////////////////////////////////////////////////////////////////////////////

  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;

  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

  // A branch finishes in EX and never waits on WB
  assign ex_ready_o = units_ready | branch_in_ex_i;

  ////////////////////////////////////////////////////////////////////////////
  // EX/WB register
  ////////////////////////////////////////////////////////////////////////////

  // Faulting accesses never write back
  assign lsu_we_masked = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsu_we_q    <= 1'b0;
      lsu_waddr_q <= '0;
    end else if (ex_valid_o) begin
      lsu_we_q <= lsu_we_masked;
      if (lsu_we_masked) begin
        lsu_waddr_q <= regfile_waddr_i;
      end
    end else if (wb_ready_i) begin
      // WB can take more but nothing came, flush the slot
      lsu_we_q <= 1'b0;
    end
  end

  // Load data arrives from the LSU in the WB cycle
  assign wb_port_o.we   = lsu_we_q;
  assign wb_port_o.addr = lsu_waddr_q;
  assign wb_port_o.data = lsu_rdata_i;

endmodule

/* rtl/mult/ex_mult.sv */
/*
  Integer multiplier. MUL and MAC are combinational and keep ready high.
  MULH, MULHSU and MULHU iterate over MULH_STEPS cycles, one slice of b each.
  Operands must stay stable until the upper word is taken with ex_ready_i.
*/

`timescale 1ns/1ns

module ex_mult
  import ex_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            enable_i,
  input  mult_req_t       mult_req_i,
  input  logic            ex_ready_i,
  output logic [XLEN-1:0] result_o,
  output logic            multicycle_o,
  output logic            ready_o
);

  typedef enum logic [1:0] {
    MH_IDLE,
    MH_STEP,
    MH_DONE
  } mulh_state_e;

  mulh_state_e           state_q;
  logic [MULH_CNT_W-1:0] cnt_q;
  logic [2*XLEN-1:0]     acc_q;

  // Low products
  logic [XLEN-1:0] prod_lo;

  // Upper-word datapath
  logic                    is_mulh;
  logic                    start;
  logic                    a_signed;
  logic                    b_signed;
  logic [MULH_CNT_W-1:0]   cur_step;
  logic [MULH_SLICE_W-1:0] b_slice;
  logic                    slice_sign;
  logic [2*XLEN-1:0]       a_ext;
  logic [2*XLEN-1:0]       b_ext;
  logic [2*XLEN-1:0]       partial;
  logic [2*XLEN-1:0]       acc_next;

  ////////////////////////////////////////////////////////////////////////////
  // Single-cycle low word
  ////////////////////////////////////////////////////////////////////////////

  // Low 32 bits are the same for signed and unsigned operands
  assign prod_lo = mult_req_i.a * mult_req_i.b;

  ////////////////////////////////////////////////////////////////////////////
  // Upper-word iteration
  ////////////////////////////////////////////////////////////////////////////

  assign is_mulh = (mult_req_i.op == MULT_MULH) || (mult_req_i.op == MULT_MULHSU) ||
                   (mult_req_i.op == MULT_MULHU);

  // First cycle seen enabled is handled in the idle state itself
  assign start = enable_i & is_mulh & (state_q == MH_IDLE);

  assign a_signed = (mult_req_i.op == MULT_MULH) || (mult_req_i.op == MULT_MULHSU);
  assign b_signed = (mult_req_i.op == MULT_MULH);

  // Slice 0 in the start cycle and the counter after it
  assign cur_step = (state_q == MH_IDLE) ? '0 : cnt_q;
  assign b_slice  = mult_req_i.b[cur_step*MULH_SLICE_W +: MULH_SLICE_W];

  // Only the top slice of a signed b carries the negative weight -2^(XLEN-1)
  assign slice_sign = b_signed & (cur_step == MULH_CNT_W'(MULH_STEPS - 1)) &
                      b_slice[MULH_SLICE_W-1];

  // a extended to 64 bits by its signedness
  assign a_ext = {{XLEN{a_signed & mult_req_i.a[XLEN-1]}}, mult_req_i.a};

  // Slice of b with sign extension only for the top slice of a signed b
  assign b_ext = {{(2*XLEN-MULH_SLICE_W){slice_sign}}, b_slice};

  // Slice product modulo 2^64 shifted to its weight
  assign partial = (a_ext * b_ext) << (cur_step * MULH_SLICE_W);

  // Accumulator starts from zero on the first step
  assign acc_next = ((state_q == MH_IDLE) ? '0 : acc_q) + partial;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MH_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        MH_IDLE: begin
          if (start) begin
            cnt_q   <= MULH_CNT_W'(1);
            state_q <= MH_STEP;
          end
        end
        MH_STEP: begin
          cnt_q <= cnt_q + MULH_CNT_W'(1);
          // After the last slice the upper word is presented next cycle
          if (cnt_q == MULH_CNT_W'(MULH_STEPS - 1)) begin
            state_q <= MH_DONE;
          end
        end
        MH_DONE: begin
          // Hold until the pipeline takes it
          if (ex_ready_i) begin
            state_q <= MH_IDLE;
          end
        end
        default: state_q <= MH_IDLE;
      endcase
    end
  end

  // Partial sum of the upper-word product
  always_ff @(posedge clk) begin
    if (start || (state_q == MH_STEP)) begin
      acc_q <= acc_next;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  // Low while slices are being accumulated
  assign multicycle_o = start | (state_q == MH_STEP);
  assign ready_o      = ~multicycle_o;

  always_comb begin
    if (state_q == MH_DONE) begin
      result_o = acc_q[2*XLEN-1:XLEN];
    end else if (mult_req_i.op == MULT_MAC) begin
      result_o = prod_lo + mult_req_i.c;
    end else begin
      result_o = prod_lo;
    end
  end

endmodule

/* tb/ex_stage_assert.sv */
/*
  Concurrent checks on the stage handshake and reset, bound into ex_stage.
  Needs the simulator's assertion support switched on.
*/

`timescale 1ns/1ns

module ex_stage_assert
  import ex_pkg::*;
(
  input logic     clk,
  input logic     rst_n,
  input logic     wb_ready_i,
  input logic     ex_valid_i,
  input logic     mult_multicycle_i,
  input logic     lsu_err_i,
  input wb_port_t wb_port_i
);

  // Count of failed assertions for the closing report of the run
  int fail_count = 0;

  // Nothing retires while WB is stalled
  valid_needs_wb_ready: assert property (
    @(posedge clk) disable iff (!rst_n) !wb_ready_i |-> !ex_valid_i
  ) else begin
    $error("ex_valid_o high while wb_ready_i is low");
    fail_count++;
  end

  // Multiplier leaves reset idle
  mult_idle_after_reset: assert property (
    @(posedge clk) $rose(rst_n) |-> !mult_multicycle_i
  ) else begin
    $error("mult_multicycle_o high right after reset");
    fail_count++;
  end

  // A faulting access never reaches the load/store port
  lsu_err_masks_we: assert property (
    @(posedge clk) disable iff (!rst_n) (ex_valid_i && lsu_err_i) |=> !wb_port_i.we
  ) else begin
    $error("wb_port_o.we set by an access with lsu_err_i");
    fail_count++;
  end

endmodule

bind ex_stage ex_stage_assert u_assert (
  .clk               (clk),
  .rst_n             (rst_n),
  .wb_ready_i        (wb_ready_i),
  .ex_valid_i        (ex_valid_o),
  .mult_multicycle_i (mult_multicycle_o),
  .lsu_err_i         (lsu_err_i),
  .wb_port_i         (wb_port_o)
);

/* tb/ex_stage_tb.sv */
/*
  Testbench of the execute stage: LFSR stimulus driven on the falling edge,
  results compared on the rising edge where ex_valid_o is high.
  Expects wb_ready and lsu_ready high except in the back-pressure test.
*/

`timescale 1ns/1ns

module ex_stage_tb
  import ex_pkg::*;
();

  localparam int NUM_ALU   = 48;
  localparam int NUM_MULT  = 24;
  localparam int NUM_TESTS = NUM_ALU + NUM_MULT + 16;

  logic                  clk;
  logic                  rst_n;
  logic                  alu_en;
  alu_req_t              alu_req;
  logic                  mult_en;
  mult_req_t             mult_req;
  logic [XLEN-1:0]       jump_src;
  logic                  csr_access;
  logic [XLEN-1:0]       csr_rdata;
  logic                  lsu_en;
  logic [XLEN-1:0]       lsu_rdata;
  logic                  lsu_ready_ex;
  logic                  lsu_err;
  logic                  branch_in_ex;
  logic                  regfile_alu_we;
  logic [REG_ADDR_W-1:0] regfile_alu_waddr;
  logic                  regfile_we;
  logic [REG_ADDR_W-1:0] regfile_waddr;
  logic                  wb_ready;
  wb_port_t              fw_port;
  wb_port_t              wb_port;
  logic                  branch_decision;
  logic [XLEN-1:0]       jump_target;
  logic                  mult_multicycle;
  logic                  ex_ready;
  logic                  ex_valid;

  // Scoreboard state is written on the falling edge and read on the rising edge
  logic [31:0] lfsr;
  logic [31:0] exp_data;
  logic        exp_cmp;
  string       test_name;
  int          checks;
  int          errors;

  ex_stage uut (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_en_i            (alu_en),
    .alu_req_i           (alu_req),
    .mult_en_i           (mult_en),
    .mult_req_i          (mult_req),
    .jump_target_src_i   (jump_src),
    .csr_access_i        (csr_access),
    .csr_rdata_i         (csr_rdata),
    .lsu_en_i            (lsu_en),
    .lsu_rdata_i         (lsu_rdata),
    .lsu_ready_ex_i      (lsu_ready_ex),
    .lsu_err_i           (lsu_err),
    .branch_in_ex_i      (branch_in_ex),
    .regfile_alu_we_i    (regfile_alu_we),
    .regfile_alu_waddr_i (regfile_alu_waddr),
    .regfile_we_i        (regfile_we),
    .regfile_waddr_i     (regfile_waddr),
    .wb_ready_i          (wb_ready),
    .fw_port_o           (fw_port),
    .wb_port_o           (wb_port),
    .branch_decision_o   (branch_decision),
    .jump_target_o       (jump_target),
    .mult_multicycle_o   (mult_multicycle),
    .ex_ready_o          (ex_ready),
    .ex_valid_o          (ex_valid)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Random source and reference model
  ////////////////////////////////////////////////////////////////////////////

  // Taps x^32 + x^22 + x^2 + x + 1 with the new bit entering at the bottom
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic draw(input int n, output logic [31:0] val);
    int i;
    val = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
  endtask

  function automatic logic ref_cmp(alu_req_t r);
    case (r.op)
      ALU_EQ:          return r.a == r.b;
      ALU_NE:          return r.a != r.b;
      ALU_SLT, ALU_LT: return $signed(r.a) < $signed(r.b);
      ALU_GE:          return $signed(r.a) >= $signed(r.b);
      ALU_SLTU, ALU_LTU: return r.a < r.b;
      ALU_GEU:         return r.a >= r.b;
      default:         return 1'b0;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] ref_alu(alu_req_t r);
    case (r.op)
      ALU_ADD: return r.a + r.b;
      ALU_SUB: return r.a - r.b;
      ALU_XOR: return r.a ^ r.b;
      ALU_OR:  return r.a | r.b;
      ALU_AND: return r.a & r.b;
      ALU_SLL: return r.a << r.b[4:0];
      ALU_SRL: return r.a >> r.b[4:0];
      // Logical shift with the vacated top bits filled by the sign of a
      ALU_SRA: return (r.a >> r.b[4:0]) |
                      (~({XLEN{1'b1}} >> r.b[4:0]) & {XLEN{r.a[XLEN-1]}});
      default: return {{(XLEN-1){1'b0}}, ref_cmp(r)};
    endcase
  endfunction

  // Full 64-bit product of the extended operands taken modulo 2^64
  function automatic logic [XLEN-1:0] ref_mult(mult_req_t r);
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] p;
    ea = {{32{(r.op != MULT_MULHU) & r.a[31]}}, r.a};
    eb = {{32{(r.op == MULT_MULH) & r.b[31]}}, r.b};
    p  = ea * eb;
    case (r.op)
      MULT_MUL: return p[31:0];
      MULT_MAC: return p[31:0] + r.c;
      default:  return p[63:32];
    endcase
  endfunction

  // CSR over multiplier over ALU and zero when none is enabled
  function automatic logic [XLEN-1:0] ref_fw();
    if (csr_access) return csr_rdata;
    if (mult_en) return ref_mult(mult_req);
    if (alu_en) return ref_alu(alu_req);
    return '0;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checking
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
    checks++;
    assert (exp == act) else begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // Forwarding port, ready, branch outcome and target on every accepted cycle
  always @(posedge clk) begin
    if (rst_n && ex_valid) begin
      check_value({test_name, " fw data"}, exp_data, fw_port.data);
      check_value({test_name, " fw we"}, 32'(regfile_alu_we), 32'(fw_port.we));
      check_value({test_name, " fw addr"}, 32'(regfile_alu_waddr), 32'(fw_port.addr));
      check_value({test_name, " ready"}, 32'd1, 32'(ex_ready));
      check_value({test_name, " branch"}, 32'(exp_cmp), 32'(branch_decision));
      check_value({test_name, " jump target"}, jump_src, jump_target);
    end
  end

  task automatic check_wb(string name, logic exp_we, logic [REG_ADDR_W-1:0] exp_addr);
    check_value({name, " wb we"}, 32'(exp_we), 32'(wb_port.we));
    check_value({name, " wb addr"}, 32'(exp_addr), 32'(wb_port.addr));
    check_value({name, " wb data"}, lsu_rdata, wb_port.data);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic clear_inputs();
    alu_en       = 1'b0;
    mult_en      = 1'b0;
    csr_access   = 1'b0;
    lsu_en       = 1'b0;
    lsu_err      = 1'b0;
    branch_in_ex = 1'b0;
    regfile_we   = 1'b0;
    lsu_ready_ex = 1'b1;
    wb_ready     = 1'b1;
  endtask

  task automatic random_alu();
    logic [31:0] v;
    draw(4, v);
    alu_req.op = alu_op_e'(v[3:0]);
    draw(32, v);
    alu_req.a = v;
    draw(32, v);
    alu_req.b = v;
    // Equal operands now and then so EQ and GE see both outcomes
    draw(2, v);
    if (v[1:0] == 2'd0) alu_req.b = alu_req.a;
    draw(32, v);
    jump_src = v;
    draw(REG_ADDR_W, v);
    regfile_alu_waddr = v[REG_ADDR_W-1:0];
    regfile_alu_we    = 1'b1;
    alu_en            = 1'b1;
  endtask

  task automatic random_mult();
    logic [31:0] v;
    draw(3, v);
    if (v[2:0] > 3'd4) v = v - 32'd3;
    mult_req.op = mult_op_e'(v[2:0]);
    draw(32, v);
    mult_req.a = v;
    draw(32, v);
    mult_req.b = v;
    draw(32, v);
    mult_req.c = v;
    mult_en    = 1'b1;
  endtask

  // Ready low and multicycle high are counted up to the accepting edge
  task automatic wait_valid(output int stall, output int mc);
    stall = 0;
    mc    = 0;
    @(posedge clk);
    while (!ex_valid) begin
      if (!ex_ready) stall++;
      if (mult_multicycle) mc++;
      @(posedge clk);
    end
  endtask

  task automatic run_op(string name, bit multi);
    int stall;
    int mc;
    int exp_stall;
    exp_stall = multi ? MULH_STEPS : 0;
    test_name = name;
    exp_data  = ref_fw();
    exp_cmp   = ref_cmp(alu_req);
    wait_valid(stall, mc);
    check_value({name, " ready low cycles"}, exp_stall, stall);
    check_value({name, " multicycle cycles"}, exp_stall, mc);
    @(negedge clk);
  endtask

  task automatic mulh_corner(mult_op_e op, logic [31:0] a, logic [31:0] b);
    clear_inputs();
    mult_req = '{op: op, a: a, b: b, c: '0};
    mult_en  = 1'b1;
    run_op("mulh_corner", 1'b1);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] v;
    logic [REG_ADDR_W-1:0] held_addr;
    int i;
    lfsr = 32'h47d2;
    checks = 0;
    errors = 0;
    test_name = "reset";
    exp_data = '0;
    exp_cmp = 1'b0;
    alu_req = '0;
    mult_req = '0;
    jump_src = '0;
    csr_rdata = '0;
    lsu_rdata = '0;
    regfile_alu_we = 1'b0;
    regfile_alu_waddr = '0;
    regfile_waddr = '0;
    clear_inputs();
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    for (i = 0; i < NUM_ALU; i++) begin
      clear_inputs();
      random_alu();
      run_op("alu_random", 1'b0);
    end

    // Mixed low and upper-word multiplies
    for (i = 0; i < NUM_MULT; i++) begin
      clear_inputs();
      random_mult();
      run_op("mult_random", mult_req.op inside {MULT_MULH, MULT_MULHSU, MULT_MULHU});
    end
    mulh_corner(MULT_MULH, 32'h8000_0000, 32'h8000_0000);
    mulh_corner(MULT_MULHSU, 32'hffff_ffff, 32'hffff_ffff);
    mulh_corner(MULT_MULHU, 32'hffff_ffff, 32'hffff_ffff);

    // Priority of the forwarding data
    clear_inputs();
    random_alu();
    csr_access = 1'b1;
    draw(32, v);
    csr_rdata = v;
    run_op("prio_csr_alu", 1'b0);
    clear_inputs();
    random_mult();
    mult_req.op = MULT_MUL;
    csr_access = 1'b1;
    run_op("prio_csr_mult", 1'b0);
    clear_inputs();
    random_alu();
    random_mult();
    mult_req.op = MULT_MAC;
    run_op("prio_mult_alu", 1'b0);

    // Load/store port write, error masking and flush
    clear_inputs();
    lsu_en = 1'b1;
    regfile_we = 1'b1;
    draw(REG_ADDR_W, v);
    regfile_waddr = v[REG_ADDR_W-1:0];
    draw(32, v);
    lsu_rdata = v;
    run_op("lsu_write", 1'b0);
    check_wb("lsu_write", 1'b1, regfile_waddr);
    held_addr = regfile_waddr;
    lsu_err = 1'b1;
    regfile_waddr = ~held_addr;
    run_op("lsu_error", 1'b0);
    check_wb("lsu_error", 1'b0, held_addr);
    lsu_err = 1'b0;
    run_op("lsu_rewrite", 1'b0);
    check_wb("lsu_rewrite", 1'b1, regfile_waddr);
    held_addr = regfile_waddr;
    clear_inputs();
    @(negedge clk);
    check_wb("lsu_flush", 1'b0, held_addr);

    // Back-pressure holds the stage and the EX/WB register
    lsu_en = 1'b1;
    regfile_we = 1'b1;
    run_op("lsu_refill", 1'b0);
    check_wb("lsu_refill", 1'b1, held_addr);
    random_alu();
    regfile_waddr = ~held_addr;
    wb_ready = 1'b0;
    repeat (3) begin
      @(negedge clk);
      check_value("backpressure valid", 32'd0, 32'(ex_valid));
      check_value("backpressure ready", 32'd0, 32'(ex_ready));
      check_wb("backpressure", 1'b1, held_addr);
    end
    branch_in_ex = 1'b1;
    @(posedge clk);
    check_value("branch ready", 32'd1, 32'(ex_ready));
    check_value("branch valid", 32'd0, 32'(ex_valid));
    @(negedge clk);
    branch_in_ex = 1'b0;
    wb_ready = 1'b1;
    run_op("backpressure_release", 1'b0);
    check_wb("backpressure_release", 1'b1, regfile_waddr);
    clear_inputs();
    @(negedge clk);

    errors = errors + uut.u_assert.fail_count;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Worst case per test is one upper-word multiply plus setup cycles
  initial begin
    repeat (NUM_TESTS * (MULH_STEPS + 3) + 100) @(posedge clk);
    $display("Timeout: the DUT did not raise ex_valid_o within the expected time");
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* verilog.f */
common/ex_pkg.sv
rtl/alu/ex_alu.sv
rtl/mult/ex_mult.sv
rtl/ex_writeback.sv
rtl/ex_stage.sv
tb/ex_stage_assert.sv
tb/ex_stage_tb.sv
